//--- src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // Address and data width.
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  // Address split: tag | index | block offset | byte offset.
  localparam int BYTE_OFF_W = 2;
  localparam int DBLK_W     = 1;  // Two words per block.
  localparam int DIDX_W     = 3;
  localparam int N_SETS     = 2**DIDX_W;
  localparam int DTAG_W     = WORD_W - DIDX_W - DBLK_W - BYTE_OFF_W;

  localparam int N_WAYS = 2;

  // Hit count lands here once the flush is done.
  localparam word_t HIT_COUNT_ADDR = 32'h0000_3100;

  // Control unit states.
  typedef enum logic [3:0] {
    IDLE,
    WB0,          // Victim word 0 out.
    WB1,          // Victim word 1 out.
    LOAD0,        // Fill word 0.
    LOAD1,        // Fill word 1, then tag and valid.
    FLUSH_CHECK,
    FLUSH_WB0,
    FLUSH_WB1,
    STORE_COUNT,
    FLUSHED
  } dcu_state_t;

endpackage

`default_nettype wire

//--- src/dcache_frame_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_frame_array
  import dcache_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic [DIDX_W-1:0] idx,
  input  logic [DTAG_W-1:0] tag,
  input  logic              blkoff,
  input  word_t             wdata,
  input  logic              write_word,
  input  logic              write_tag,
  input  logic              set_valid,
  input  logic              mark_dirty,
  output logic              hit,
  output logic              valid,
  output logic              dirty,
  output logic [DTAG_W-1:0] out_tag,
  output word_t             out_word0,
  output word_t             out_word1
);

  logic [N_SETS-1:0] valid_r;
  logic [N_SETS-1:0] dirty_r;
  logic [DTAG_W-1:0] tag_mem [N_SETS];
  word_t             word0_mem [N_SETS];
  word_t             word1_mem [N_SETS];

  // Status bits.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid_r <= '0;
      dirty_r <= '0;
    end
    else if (write_word)
    begin
      dirty_r[idx] <= mark_dirty;  // Fill leaves it clean, store dirty.
      if (set_valid)
        valid_r[idx] <= 1'b1;
    end
  end

  // Tag and data storage.
  always_ff @(posedge CLK)
  begin
    if (write_word)
    begin
      if (blkoff)
        word1_mem[idx] <= wdata;
      else
        word0_mem[idx] <= wdata;
      if (write_tag)
        tag_mem[idx] <= tag;
    end
  end

  assign valid     = valid_r[idx];
  assign dirty     = dirty_r[idx];
  assign out_tag   = tag_mem[idx];
  assign out_word0 = word0_mem[idx];
  assign out_word1 = word1_mem[idx];

  // Valid entry with matching tag.
  assign hit = valid_r[idx] && (tag_mem[idx] == tag);

endmodule

`default_nettype wire

//--- src/dcache_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_control_unit
  import dcache_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  word_t             dmemaddr,
  input  logic              halt,
  input  logic              hit0,
  input  logic              hit1,
  input  logic              lru_sel,
  input  logic              victim_valid,
  input  logic              victim_dirty,
  input  logic [DTAG_W-1:0] victim_tag,
  input  word_t             victim_word0,
  input  word_t             victim_word1,
  input  logic              dwait,
  input  word_t             hit_count,
  output logic [DIDX_W-1:0] cache_idx,
  output logic [DTAG_W-1:0] cache_tag,
  output logic              cache_blkoff,
  output logic              fill_word,
  output logic              fill_last,
  output logic              fill_way,
  output logic              status_way,
  output logic              dREN,
  output logic              dWEN,
  output word_t             daddr,
  output word_t             dstore,
  output logic              counter_hold,
  output logic              flushed
);

  dcu_state_t state;
  dcu_state_t next_state;

  logic              mem_ready;
  logic              miss;
  logic              victim_wb;
  logic              flush_advance;
  logic              flush_last;
  logic [DIDX_W-1:0] flush_idx;
  logic              flush_way;
  logic [DTAG_W-1:0] req_tag;
  logic [DIDX_W-1:0] req_idx;
  logic              in_flush;

  assign mem_ready = ~dwait;

  // Request address fields.
  assign req_tag = dmemaddr[WORD_W-1 -: DTAG_W];
  assign req_idx = dmemaddr[BYTE_OFF_W+DBLK_W +: DIDX_W];

  assign miss      = (dmemREN || dmemWEN) && !hit0 && !hit1;
  assign victim_wb = victim_valid && victim_dirty;

  assign in_flush = (state == FLUSH_CHECK) || (state == FLUSH_WB0) ||
                    (state == FLUSH_WB1) || (state == STORE_COUNT) || (state == FLUSHED);

  // Step past a clean entry, or past one just written back.
  assign flush_advance = ((state == FLUSH_CHECK) && !victim_wb) ||
                         ((state == FLUSH_WB1) && mem_ready);
  assign flush_last    = (flush_idx == DIDX_W'(N_SETS-1)) && (flush_way == 1'(N_WAYS-1));

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= IDLE;
      fill_way  <= 1'b0;
      flush_idx <= '0;
      flush_way <= 1'b0;
    end
    else
    begin
      state <= next_state;
      if ((state == IDLE) && !halt && miss)
        fill_way <= lru_sel;  // LRU way takes the new block.
      if (flush_advance)
      begin
        // Ways inner, sets outer.
        if (flush_way == 1'(N_WAYS-1))
        begin
          flush_way <= 1'b0;
          flush_idx <= flush_idx + 1'b1;
        end
        else
          flush_way <= flush_way + 1'b1;
      end
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        if (halt)
          next_state = FLUSH_CHECK;
        else if (miss)
          next_state = victim_wb ? WB0 : LOAD0;
      end
      WB0:         if (mem_ready) next_state = WB1;
      WB1:         if (mem_ready) next_state = LOAD0;
      LOAD0:       if (mem_ready) next_state = LOAD1;
      LOAD1:       if (mem_ready) next_state = IDLE;
      FLUSH_CHECK:
      begin
        if (victim_wb)
          next_state = FLUSH_WB0;
        else if (flush_last)
          next_state = STORE_COUNT;
      end
      FLUSH_WB0:   if (mem_ready) next_state = FLUSH_WB1;
      FLUSH_WB1:
      begin
        if (mem_ready)
          next_state = flush_last ? STORE_COUNT : FLUSH_CHECK;
      end
      STORE_COUNT: if (mem_ready) next_state = FLUSHED;
      FLUSHED:     next_state = FLUSHED;  // Held until reset.
      default:     next_state = IDLE;
    endcase
  end

  // Way array addressing.
  always_comb
  begin
    cache_tag    = req_tag;
    cache_idx    = in_flush ? flush_idx : req_idx;
    cache_blkoff = dmemaddr[BYTE_OFF_W];
    case (state)
      WB0, LOAD0, FLUSH_WB0: cache_blkoff = 1'b0;
      WB1, LOAD1, FLUSH_WB1: cache_blkoff = 1'b1;
      default:               cache_blkoff = dmemaddr[BYTE_OFF_W];
    endcase
  end

  // Memory side requests and fill strobes.
  always_comb
  begin
    dREN      = 1'b0;
    dWEN      = 1'b0;
    daddr     = '0;
    dstore    = '0;
    fill_word = 1'b0;
    fill_last = 1'b0;
    case (state)
      WB0, FLUSH_WB0:
      begin
        dWEN   = 1'b1;
        daddr  = {victim_tag, cache_idx, 1'b0, {BYTE_OFF_W{1'b0}}};
        dstore = victim_word0;
      end
      WB1, FLUSH_WB1:
      begin
        dWEN   = 1'b1;
        daddr  = {victim_tag, cache_idx, 1'b1, {BYTE_OFF_W{1'b0}}};
        dstore = victim_word1;
      end
      LOAD0:
      begin
        dREN      = 1'b1;
        daddr     = {req_tag, req_idx, 1'b0, {BYTE_OFF_W{1'b0}}};
        fill_word = mem_ready;
      end
      LOAD1:
      begin
        dREN      = 1'b1;
        daddr     = {req_tag, req_idx, 1'b1, {BYTE_OFF_W{1'b0}}};
        fill_word = mem_ready;
        fill_last = mem_ready;  // Tag and valid with the last word.
      end
      STORE_COUNT:
      begin
        dWEN   = 1'b1;
        daddr  = HIT_COUNT_ADDR;
        dstore = hit_count;
      end
      default:
      begin
        dREN = 1'b0;
        dWEN = 1'b0;
      end
    endcase
  end

  assign status_way   = flush_way;
  assign counter_hold = in_flush;
  assign flushed      = (state == FLUSHED);

endmodule

`default_nettype wire

//--- src/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache
  import dcache_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmemREN,
  input  logic  dmemWEN,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  input  logic  halt,
  input  logic  dwait,
  input  word_t dload,
  output logic  dhit,
  output word_t dmemload,
  output logic  flushed,
  output logic  dREN,
  output logic  dWEN,
  output word_t daddr,
  output word_t dstore
);

  logic [DIDX_W-1:0] cache_idx;
  logic [DTAG_W-1:0] cache_tag;
  logic              cache_blkoff;
  logic              fill_word;
  logic              fill_last;
  logic              fill_way;
  logic              status_way;
  logic              counter_hold;
  logic              lru_sel;
  logic              victim_sel;
  logic              hit_sel;
  logic [N_SETS-1:0] lru;
  word_t             hit_count;

  // Per-way signals.
  logic [N_WAYS-1:0] hit_w;
  logic [N_WAYS-1:0] valid_w;
  logic [N_WAYS-1:0] dirty_w;
  logic [N_WAYS-1:0] write_word_w;
  logic [N_WAYS-1:0] write_tag_w;
  logic [N_WAYS-1:0] set_valid_w;
  logic [N_WAYS-1:0] mark_dirty_w;
  logic [DTAG_W-1:0] tag_w   [N_WAYS];
  word_t             word0_w [N_WAYS];
  word_t             word1_w [N_WAYS];
  word_t             wdata_w [N_WAYS];

  dcache_frame_array u_frame0 (
    .CLK, .nRST,
    .idx(cache_idx), .tag(cache_tag), .blkoff(cache_blkoff),
    .wdata(wdata_w[0]), .write_word(write_word_w[0]), .write_tag(write_tag_w[0]),
    .set_valid(set_valid_w[0]), .mark_dirty(mark_dirty_w[0]),
    .hit(hit_w[0]), .valid(valid_w[0]), .dirty(dirty_w[0]),
    .out_tag(tag_w[0]), .out_word0(word0_w[0]), .out_word1(word1_w[0])
  );

  dcache_frame_array u_frame1 (
    .CLK, .nRST,
    .idx(cache_idx), .tag(cache_tag), .blkoff(cache_blkoff),
    .wdata(wdata_w[1]), .write_word(write_word_w[1]), .write_tag(write_tag_w[1]),
    .set_valid(set_valid_w[1]), .mark_dirty(mark_dirty_w[1]),
    .hit(hit_w[1]), .valid(valid_w[1]), .dirty(dirty_w[1]),
    .out_tag(tag_w[1]), .out_word0(word0_w[1]), .out_word1(word1_w[1])
  );

  assign lru_sel    = lru[cache_idx];
  assign victim_sel = counter_hold ? status_way : lru_sel;  // Flush walks the ways.

  dcache_control_unit u_control (
    .CLK, .nRST,
    .dmemREN, .dmemWEN, .dmemaddr, .halt,
    .hit0(hit_w[0]), .hit1(hit_w[1]), .lru_sel,
    .victim_valid(valid_w[victim_sel]), .victim_dirty(dirty_w[victim_sel]),
    .victim_tag(tag_w[victim_sel]),
    .victim_word0(word0_w[victim_sel]), .victim_word1(word1_w[victim_sel]),
    .dwait, .hit_count,
    .cache_idx, .cache_tag, .cache_blkoff,
    .fill_word, .fill_last, .fill_way, .status_way,
    .dREN, .dWEN, .daddr, .dstore,
    .counter_hold, .flushed
  );

  // Misses never hit, so only the flush needs masking.
  assign dhit = (dmemREN || dmemWEN) && (|hit_w) && !counter_hold;

  assign hit_sel  = hit_w[1];
  assign dmemload = cache_blkoff ? word1_w[hit_sel] : word0_w[hit_sel];

  // Store hits and fill data into the right way.
  always_comb
  begin
    for (int w = 0; w < N_WAYS; w++)
    begin
      wdata_w[w]      = dload;
      write_word_w[w] = 1'b0;
      write_tag_w[w]  = 1'b0;
      set_valid_w[w]  = 1'b0;
      mark_dirty_w[w] = 1'b0;
      if (dhit && dmemWEN && hit_w[w])
      begin
        wdata_w[w]      = dmemstore;
        write_word_w[w] = 1'b1;
        mark_dirty_w[w] = 1'b1;
      end
      else if (fill_word && (fill_way == 1'(w)))
      begin
        write_word_w[w] = 1'b1;
        write_tag_w[w]  = fill_last;
        set_valid_w[w]  = fill_last;
      end
    end
  end

  // LRU bit names the way that did not hit.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      lru <= '0;
    else if (dhit)
      lru[cache_idx] <= ~hit_w[1];
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      hit_count <= '0;
    else if (dhit && !counter_hold)
      hit_count <= hit_count + 1'b1;  // One per completed request.
  end

endmodule

`default_nettype wire

//--- tests/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
  import dcache_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dREN,
  input  logic  dWEN,
  input  word_t daddr,
  input  word_t dstore,
  output logic  dwait,
  output word_t dload
);

  localparam int          MEM_WORDS = 1024;
  localparam int          IDX_W     = 10;
  localparam logic [31:0] SEED      = 32'd68556;

  word_t            mem [MEM_WORDS];
  logic [IDX_W-1:0] widx;
  logic [31:0]      lfsr;
  logic [31:0]      lfsr_1;
  logic [31:0]      lfsr_2;
  logic [1:0]       wait_left;
  logic             req;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // Known contents, a hash of the byte address.
  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = ((word_t'(i) << 2) * 32'h9E37_79B1) ^ 32'hA5A5_0F0F;
  end

  assign req    = dREN || dWEN;
  assign widx   = daddr[IDX_W+1:2];  // Word address, wraps at 4 KB.
  assign dwait  = req && (wait_left != 2'd0);
  assign dload  = mem[widx];
  assign lfsr_1 = lfsr_next(lfsr);
  assign lfsr_2 = lfsr_next(lfsr_1);

  always @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      lfsr      <= SEED;
      wait_left <= 2'd1;
    end
    else if (req)
    begin
      if (wait_left != 2'd0)
        wait_left <= wait_left - 2'd1;
      else
      begin
        wait_left <= {lfsr[0], lfsr_1[0]};  // 0 to 3 cycles for the next access.
        lfsr      <= lfsr_2;
      end
    end
  end

  always @(posedge CLK)
  begin
    if (dWEN && !dwait)
      mem[widx] <= dstore;
  end

endmodule

`default_nettype wire

//--- tests/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
();

  localparam int    MEM_WORDS  = 1024;
  localparam int    N_RANDOM   = 300;
  localparam int    N_DIRECTED = 7;
  localparam int    MAX_CYCLES = 200 * (N_RANDOM + N_DIRECTED) + 2000;
  localparam int    COUNT_WORD = int'(HIT_COUNT_ADDR[11:2]);
  localparam word_t ADDR_A     = 32'h0000_0208;  // All three map to set 1.
  localparam word_t ADDR_B     = 32'h0000_0288;
  localparam word_t ADDR_C     = 32'h0000_0308;

  logic  CLK, nRST, halt;
  logic  dmemREN, dmemWEN, dhit, flushed;
  logic  dREN, dWEN, dwait;
  word_t dmemaddr, dmemstore, dmemload;
  word_t daddr, dstore, dload;

  word_t       shadow [MEM_WORDS];
  word_t       wlog_addr [$];
  word_t       wlog_data [$];
  int          n_done;
  int          n_reads;
  int          n_writes;
  int          cycles;
  logic [31:0] lfsr;

  dcache u_dcache (.*);
  dcache_mem_model u_mem (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic int widx(input word_t addr);
    return int'(addr[11:2]);
  endfunction

  task automatic draw_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);  // One step per bit.
    end
  endtask

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check(input logic ok, input string what);
    assert (ok)
      else stop_with_failure($sformatf("FAIL %0t: %s", $time, what));
  endtask

  // Drive one request, wait for its dhit edge, then retire it.
  task automatic access(input logic wr, input word_t addr, input word_t data);
    dmemREN   = !wr;
    dmemWEN   = wr;
    dmemaddr  = addr;
    dmemstore = data;
    #1;
    while (!dhit)
      @(negedge CLK);
    @(negedge CLK);
    if (wr)
      shadow[widx(addr)] = data;
    n_done  = n_done + 1;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
  endtask

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Cycle limit and completed memory traffic.
  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES)
      stop_with_failure($sformatf("Timeout: run did not end within %0d cycles", MAX_CYCLES));
    if (nRST && !dwait && dREN)
      n_reads = n_reads + 1;
    if (nRST && !dwait && dWEN)
    begin
      n_writes = n_writes + 1;
      wlog_addr.push_back(daddr);
      wlog_data.push_back(dstore);
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    (dhit && dmemREN) |-> (dmemload == shadow[dmemaddr[11:2]]))
    else stop_with_failure($sformatf("FAIL %0t: load %h gave %h, expected %h",
                                     $time, dmemaddr, dmemload, shadow[dmemaddr[11:2]]));

  // Requests hold still under dwait.
  assert property (@(posedge CLK) disable iff (!nRST)
    ((dREN || dWEN) && dwait) |=>
      ($stable(dREN) && $stable(dWEN) && $stable(daddr) && $stable(dstore)))
    else stop_with_failure($sformatf("FAIL %0t: memory request changed under dwait", $time));

  assert property (@(posedge CLK) disable iff (!nRST)
    !(dREN && dWEN) && !(dhit && (dREN || dWEN)))
    else stop_with_failure($sformatf("FAIL %0t: dREN %b dWEN %b dhit %b together",
                                     $time, dREN, dWEN, dhit));

  assert property (@(posedge CLK) disable iff (!nRST)
    dREN |-> (daddr[31:3] == dmemaddr[31:3]))
    else stop_with_failure($sformatf("FAIL %0t: fill read %h for request %h",
                                     $time, daddr, dmemaddr));

  assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
    else stop_with_failure($sformatf("FAIL %0t: flushed dropped", $time));

  initial
  begin
    word_t r;
    word_t a;
    word_t d;
    int    reads0;
    int    writes0;
    nRST      = 1'b0;
    halt      = 1'b0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    lfsr      = 32'd68556;
    n_done    = 0;
    n_reads   = 0;
    n_writes  = 0;
    cycles    = 0;
    for (int i = 0; i < MEM_WORDS; i++)
      shadow[i] = ((word_t'(i) << 2) * 32'h9E37_79B1) ^ 32'hA5A5_0F0F;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    #1;
    check(!dREN && !dWEN && !flushed && !dhit, "outputs not idle after reset");
    @(negedge CLK);

    access(1'b0, ADDR_A, '0);  // Cold miss.
    check(n_reads == 2 && n_writes == 0, "cold miss did not read exactly one block");

    // Store and reload stay inside the cache.
    reads0 = n_reads;
    access(1'b1, ADDR_A, 32'hCAFE_0A0A);
    access(1'b0, ADDR_A, '0);
    check(n_reads == reads0 && n_writes == 0, "hit on A went to memory");
    check(u_mem.mem[widx(ADDR_A)] != 32'hCAFE_0A0A, "store reached memory before writeback");

    // A, B, A, C: C takes the way of the dirty B.
    access(1'b1, ADDR_B, 32'h0BAD_F00D);
    access(1'b0, ADDR_A, '0);
    reads0  = n_reads;
    writes0 = n_writes;
    wlog_addr.delete();
    wlog_data.delete();
    access(1'b0, ADDR_C, '0);
    check(n_writes == writes0 + 2 && n_reads == reads0 + 2, "wrong traffic for eviction");
    check(wlog_addr[0] == {ADDR_B[31:3], 3'b000} && wlog_addr[1] == {ADDR_B[31:3], 3'b100},
          "writeback addresses are not block B");
    check(wlog_data[0] == shadow[widx({ADDR_B[31:3], 3'b000})] &&
          wlog_data[1] == shadow[widx({ADDR_B[31:3], 3'b100})], "writeback data wrong");
    reads0 = n_reads;
    access(1'b0, ADDR_A, '0);
    check(n_reads == reads0, "A was evicted instead of B");

    for (int n = 0; n < N_RANDOM; n++)
    begin
      draw_bits(1, r);
      draw_bits(6, a);
      draw_bits(32, d);
      access(r[0], {24'd0, a[5:0], 2'b00}, d);
    end

    halt = 1'b1;
    while (!flushed)
      @(negedge CLK);
    repeat (4) @(negedge CLK);
    check(u_mem.mem[COUNT_WORD] == word_t'(n_done),
          $sformatf("hit count %0d, expected %0d", u_mem.mem[COUNT_WORD], n_done));
    shadow[COUNT_WORD] = word_t'(n_done);
    for (int i = 0; i < MEM_WORDS; i++)
      check(u_mem.mem[i] == shadow[i],
            $sformatf("memory word %0d is %h, expected %h", i, u_mem.mem[i], shadow[i]));
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
src/dcache_pkg.sv
src/dcache_frame_array.sv
src/dcache_control_unit.sv
src/dcache.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= dcache_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the test result.
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
